// ==== design/sm3_expnd_ctrl.sv ====
`timescale 1ns/1ps
`include "sm3_expnd_macros.svh"

module sm3_expnd_ctrl
    import sm3_expnd_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     pad_vld_i,
    input  logic     pad_lst_i,
    input  pre_cnt_t pre_cnt_i,

    output logic     pad_rdy_o,
    output logic     win_shift_o,
    output logic     win_sel_exp_o,
    output logic     win_rpd_o,
    output logic     pre_push_o,
    output logic     pre_clr_o,
    output logic     expnd_vld_o,
    output logic     expnd_lst_o
);

    localparam blk_idx_t HEAD_LAST = blk_idx_t'(`SM3_HEAD_WORDS - 1);
    localparam blk_idx_t BLK_LAST  = blk_idx_t'(`SM3_BLK_WORDS - 1);
    localparam pre_cnt_t PRE_LAST  = pre_cnt_t'(`SM3_PRE_WORDS - 1);

    // pairs still owed after word 15, minus the cycles with ready back up
    localparam exp_cnt_t PRE_OPEN = exp_cnt_t'(`SM3_OUT_PAIRS - `SM3_BLK_WORDS
                                               + `SM3_HEAD_WORDS - `SM3_PRE_WORDS - 1);
    localparam exp_cnt_t EXP_LAST = exp_cnt_t'(`SM3_EXP_ROUNDS - 1);

    expnd_state_e state_q;
    expnd_state_e state_d;

    blk_idx_t     idx_q;        // counts every accepted word
    exp_cnt_t     exp_cnt_q;
    logic         lst_flg_q;    // block in the window is the last one
    logic         lst_nxt_q;    // prefetched block is the last one

    logic         pad_acc;
    logic         in_block;
    logic         exp_push;

    //////////////////////////////////////////////////////////////////////
    // handshake and strobes
    //////////////////////////////////////////////////////////////////////

    assign pad_rdy_o = (state_q != st_expand);  // blocked only while expanding
    assign pad_acc   = pad_vld_i & pad_rdy_o;

    assign in_block = (state_q == st_idle) || (state_q == st_load_head)
                   || (state_q == st_stream);
    assign exp_push = (state_q == st_expand) || (state_q == st_expand_pre);

    assign win_shift_o   = (in_block && pad_acc) || exp_push;
    assign win_sel_exp_o = exp_push;
    assign win_rpd_o     = (state_q == st_rapid_load) && pad_acc;

    // words of the next block while the current one drains
    assign pre_push_o = pad_acc && ((state_q == st_expand_pre)
                                 || (state_q == st_expand_fin)
                                 || (state_q == st_wait_pre));
    assign pre_clr_o  = win_rpd_o;

    assign expnd_vld_o = ((state_q == st_stream) && pad_acc) || exp_push
                      || (state_q == st_expand_fin);
    assign expnd_lst_o = lst_flg_q && (state_q == st_expand_fin);

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (pad_acc) state_d = st_load_head;
            end
            st_load_head: begin
                if (pad_acc && idx_q == HEAD_LAST) state_d = st_stream;
            end
            st_stream: begin
                if (pad_acc && idx_q == BLK_LAST) state_d = st_expand;
            end
            st_expand: begin
                if (exp_cnt_q == PRE_OPEN) state_d = st_expand_pre;
            end
            st_expand_pre: begin
                if (exp_cnt_q == EXP_LAST) state_d = st_expand_fin;
            end
            st_expand_fin: begin
                if (pre_cnt_i == '0 && !pad_acc) begin
                    state_d = st_idle;                 // nothing of a next block
                end else if (pre_cnt_i == PRE_LAST && pad_acc) begin
                    state_d = st_rapid_load;
                end else begin
                    state_d = st_wait_pre;
                end
            end
            st_wait_pre: begin
                if (pre_cnt_i == PRE_LAST && pad_acc) state_d = st_rapid_load;
            end
            st_rapid_load: begin
                if (pad_acc) state_d = st_stream;      // fifth head word
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // counters and last-block flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
        end else if (pad_acc) begin
            idx_q <= idx_q + 1'b1;  // wraps to 0 after word 15
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_cnt_q <= '0;
        end else if (state_q == st_expand_fin) begin
            exp_cnt_q <= '0;
        end else if (exp_push) begin
            exp_cnt_q <= exp_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lst_flg_q <= 1'b0;
            lst_nxt_q <= 1'b0;
        end else if (state_q == st_expand_fin) begin
            // hand over to the block that follows
            lst_flg_q <= lst_nxt_q | (pad_acc & pad_lst_i);
            lst_nxt_q <= 1'b0;
        end else if (pad_acc && pad_lst_i) begin
            if (state_q == st_expand_pre) begin
                lst_nxt_q <= 1'b1;
            end else begin
                lst_flg_q <= 1'b1;
            end
        end
    end

    // a rapid load never overlaps a shift and only takes a full buffer
    a_shift_rpd_excl: assert property (@(posedge clk) disable iff (!rst_n)
        win_rpd_o |-> (!win_shift_o && (pre_cnt_i == pre_cnt_t'(`SM3_PRE_WORDS))));

    a_vld_only_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        pad_vld_i |-> pad_rdy_o);

endmodule

// ==== design/sm3_expnd_macros.svh ====
`ifndef SM3_EXPND_MACROS_SVH
`define SM3_EXPND_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// word and block geometry
//////////////////////////////////////////////////////////////////////

`define SM3_WORD_W      32  // message word width
`define SM3_BLK_WORDS   16  // words per padded block, also window slots

//////////////////////////////////////////////////////////////////////
// expansion schedule
//////////////////////////////////////////////////////////////////////

// words that must sit in the window before W0/W'0 can go out
`define SM3_HEAD_WORDS  5
`define SM3_EXP_ROUNDS  52  // W16 .. W67
`define SM3_OUT_PAIRS   64  // W/W' pairs per block

// next-block words held while the current block finishes
`define SM3_PRE_WORDS   4

`endif

// ==== design/sm3_expnd_pkg.sv ====
package sm3_expnd_pkg;

`include "sm3_expnd_macros.svh"

    // message or expanded word
    typedef logic [`SM3_WORD_W-1:0] sm3_word_t;

    // word index inside a block, wraps after the last word
    typedef logic [$clog2(`SM3_BLK_WORDS)-1:0] blk_idx_t;

    typedef logic [$clog2(`SM3_EXP_ROUNDS+1)-1:0] exp_cnt_t;  // pushes done
    typedef logic [$clog2(`SM3_PRE_WORDS+1)-1:0] pre_cnt_t;   // words held

    typedef enum logic [2:0] {
        st_idle,
        st_load_head,   // first words, nothing out yet
        st_stream,      // one word in, one pair out
        st_expand,      // expansion only, input blocked
        st_expand_pre,  // expansion plus prefetch of next block
        st_expand_fin,  // last pair of the block
        st_wait_pre,    // filling the prefetch buffer
        st_rapid_load   // buffer full, waiting for the fifth word
    } expnd_state_e;

endpackage

// ==== design/sm3_expnd_top.sv ====
`timescale 1ns/1ps
`include "sm3_expnd_macros.svh"

module sm3_expnd_top
    import sm3_expnd_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  sm3_word_t pad_d_i,
    input  logic      pad_vld_i,
    input  logic      pad_lst_i,
    output logic      pad_rdy_o,

    output sm3_word_t wj_o,
    output sm3_word_t wjj_o,
    output logic      expnd_vld_o,
    output logic      expnd_lst_o
);

    logic                          win_shift;
    logic                          win_sel_exp;
    logic                          win_rpd;
    logic                          pre_push;
    logic                          pre_clr;
    pre_cnt_t                      pre_cnt;
    sm3_word_t [`SM3_PRE_WORDS-1:0] pre_words;

    sm3_expnd_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .pad_vld_i     (pad_vld_i),
        .pad_lst_i     (pad_lst_i),
        .pre_cnt_i     (pre_cnt),
        .pad_rdy_o     (pad_rdy_o),
        .win_shift_o   (win_shift),
        .win_sel_exp_o (win_sel_exp),
        .win_rpd_o     (win_rpd),
        .pre_push_o    (pre_push),
        .pre_clr_o     (pre_clr),
        .expnd_vld_o   (expnd_vld_o),
        .expnd_lst_o   (expnd_lst_o)
    );

    sm3_word_window u_window (
        .clk           (clk),
        .rst_n         (rst_n),
        .win_shift_i   (win_shift),
        .win_sel_exp_i (win_sel_exp),
        .win_rpd_i     (win_rpd),
        .pad_d_i       (pad_d_i),
        .pre_words_i   (pre_words),
        .wj_o          (wj_o),
        .wjj_o         (wjj_o)
    );

    sm3_prefetch_buf u_prefetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .pre_push_i  (pre_push),
        .pre_clr_i   (pre_clr),
        .pad_d_i     (pad_d_i),
        .pre_words_o (pre_words),
        .pre_cnt_o   (pre_cnt)
    );

endmodule

// ==== design/sm3_prefetch_buf.sv ====
`timescale 1ns/1ps
`include "sm3_expnd_macros.svh"

module sm3_prefetch_buf
    import sm3_expnd_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          pre_push_i,
    input  logic                          pre_clr_i,
    input  sm3_word_t                     pad_d_i,

    output sm3_word_t [`SM3_PRE_WORDS-1:0] pre_words_o,
    output pre_cnt_t                      pre_cnt_o
);

    sm3_word_t [`SM3_PRE_WORDS-1:0] buf_q;  // index 0 oldest once full
    pre_cnt_t                      cnt_q;

    // new word enters at the top, older ones move down
    always_ff @(posedge clk) begin
        if (pre_push_i) begin
            buf_q <= {pad_d_i, buf_q[`SM3_PRE_WORDS-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (pre_clr_i) begin
            cnt_q <= '0;
        end else if (pre_push_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign pre_words_o = buf_q;
    assign pre_cnt_o   = cnt_q;

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        pre_push_i |-> (cnt_q != pre_cnt_t'(`SM3_PRE_WORDS)));

endmodule

// ==== design/sm3_word_window.sv ====
`timescale 1ns/1ps
`include "sm3_expnd_macros.svh"

module sm3_word_window
    import sm3_expnd_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          win_shift_i,
    input  logic                          win_sel_exp_i,
    input  logic                          win_rpd_i,
    input  sm3_word_t                     pad_d_i,
    input  sm3_word_t [`SM3_PRE_WORDS-1:0] pre_words_i,

    output sm3_word_t                     wj_o,
    output sm3_word_t                     wjj_o
);

    localparam int NEWEST = `SM3_BLK_WORDS - 1;

    // slot 0 holds W(j-16) when W(j) is built
    localparam int TAP_J16 = NEWEST - 15;
    localparam int TAP_J13 = NEWEST - 12;
    localparam int TAP_J9  = NEWEST - 8;
    localparam int TAP_J6  = NEWEST - 5;
    localparam int TAP_J3  = NEWEST - 2;

    localparam int OUT_TAP  = NEWEST - 4;                // W(j) while W(j+4) is newest
    localparam int RPD_BASE = NEWEST - `SM3_PRE_WORDS;   // first slot of rapid load

    sm3_word_t win_q [`SM3_BLK_WORDS];

    sm3_word_t mix_word;
    sm3_word_t exp_word;
    sm3_word_t push_word;

    function automatic sm3_word_t rotl(input sm3_word_t x, input int unsigned n);
        rotl = (x << n) | (x >> (`SM3_WORD_W - n));
    endfunction

    function automatic sm3_word_t p1(input sm3_word_t x);
        p1 = x ^ rotl(x, 15) ^ rotl(x, 23);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // expansion datapath
    //////////////////////////////////////////////////////////////////////

    assign mix_word = win_q[TAP_J16] ^ win_q[TAP_J9] ^ rotl(win_q[TAP_J3], 15);
    assign exp_word = p1(mix_word) ^ rotl(win_q[TAP_J13], 7) ^ win_q[TAP_J6];

    assign push_word = win_sel_exp_i ? exp_word : pad_d_i;

    //////////////////////////////////////////////////////////////////////
    // sixteen-word window, oldest first
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SM3_BLK_WORDS; i++) begin
                win_q[i] <= '0;
            end
        end else if (win_shift_i) begin
            for (int i = 0; i < NEWEST; i++) begin
                win_q[i] <= win_q[i + 1];
            end
            win_q[NEWEST] <= push_word;
        end else if (win_rpd_i) begin
            // four prefetched words plus the word on the bus, one cycle
            for (int i = 0; i < `SM3_PRE_WORDS; i++) begin
                win_q[RPD_BASE + i] <= pre_words_i[i];
            end
            win_q[NEWEST] <= pad_d_i;
        end
    end

    assign wj_o  = win_q[OUT_TAP];
    assign wjj_o = win_q[OUT_TAP] ^ win_q[NEWEST];  // W'(j) = W(j) ^ W(j+4)

endmodule

// ==== sources.f ====
+incdir+design
design/sm3_expnd_pkg.sv
design/sm3_expnd_ctrl.sv
design/sm3_word_window.sv
design/sm3_prefetch_buf.sv
design/sm3_expnd_top.sv
test/sm3_expnd_clkgen.sv
test/sm3_expnd_tb.sv

// ==== test/sm3_expnd_clkgen.sv ====
`timescale 1ns/1ps

module sm3_expnd_clkgen #(
    parameter int HALF_NS    = 50,  // 100 ns period
    parameter int RST_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

    // first edge is a rising one, so release lands on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== test/sm3_expnd_tb.sv ====
`timescale 1ns/1ps
`include "sm3_expnd_macros.svh"

module sm3_expnd_tb
    import sm3_expnd_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RDY_LOW_CYCLES = 49;  // 53 trailing pairs, ready back for the last four

    typedef sm3_word_t blk_arr_t [`SM3_BLK_WORDS];
    typedef sm3_word_t ext_arr_t [`SM3_OUT_PAIRS + 4];

    logic      clk;
    logic      rst_n;
    sm3_word_t pad_d_i;
    logic      pad_vld_i;
    logic      pad_lst_i;
    logic      pad_rdy_o;
    sm3_word_t wj_o;
    sm3_word_t wjj_o;
    logic      expnd_vld_o;
    logic      expnd_lst_o;

    integer    seed;
    int        pairs_expected;
    int        pairs_seen;
    blk_arr_t  blk;

    sm3_word_t exp_wj_q [$];   // expected pairs, oldest first
    sm3_word_t exp_wjj_q [$];
    logic      exp_lst_q [$];

    sm3_expnd_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    sm3_expnd_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pad_d_i     (pad_d_i),
        .pad_vld_i   (pad_vld_i),
        .pad_lst_i   (pad_lst_i),
        .pad_rdy_o   (pad_rdy_o),
        .wj_o        (wj_o),
        .wjj_o       (wjj_o),
        .expnd_vld_o (expnd_vld_o),
        .expnd_lst_o (expnd_lst_o)
    );

    //////////////////////////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s expected %h actual %h", name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic sm3_word_t rol(input sm3_word_t x, input int n);
        logic [2*`SM3_WORD_W-1:0] dbl;
        dbl = {x, x} << n;
        return dbl[2*`SM3_WORD_W-1:`SM3_WORD_W];
    endfunction

    // W0 .. W67 of one block
    function automatic ext_arr_t expand_words(input blk_arr_t words);
        ext_arr_t  w;
        sm3_word_t x;
        for (int j = 0; j < `SM3_BLK_WORDS; j++) begin
            w[j] = words[j];
        end
        for (int j = `SM3_BLK_WORDS; j < `SM3_OUT_PAIRS + 4; j++) begin
            x    = w[j-16] ^ w[j-9] ^ rol(w[j-3], 15);
            w[j] = x ^ rol(x, 15) ^ rol(x, 23) ^ rol(w[j-13], 7) ^ w[j-6];
        end
        return w;
    endfunction

    task automatic queue_expected(input blk_arr_t words, input logic lst);
        ext_arr_t w;
        w = expand_words(words);
        for (int j = 0; j < `SM3_OUT_PAIRS; j++) begin
            exp_wj_q.push_back(w[j]);
            exp_wjj_q.push_back(w[j] ^ w[j+4]);
            exp_lst_q.push_back(lst && (j == `SM3_OUT_PAIRS - 1));
        end
        pairs_expected += `SM3_OUT_PAIRS;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers, all called on a falling edge
    //////////////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    task automatic fill_random_block();
        for (int i = 0; i < `SM3_BLK_WORDS; i++) begin
            blk[i] = $random(seed);
        end
    endtask

    task automatic send_word(input sm3_word_t word, input logic lst);
        int waited;
        waited = 0;
        while (!pad_rdy_o) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("timeout waiting for pad_rdy_o to accept an input word");
            end
            @(negedge clk);
        end
        pad_vld_i = 1'b1;
        pad_d_i   = word;
        pad_lst_i = lst;
        @(negedge clk);       // taken on the rising edge in between
        pad_vld_i = 1'b0;
        pad_lst_i = 1'b0;
        pad_d_i   = '0;
    endtask

    // ready drops right after word 15 and stays low while the core expands
    task automatic measure_ready_low();
        int low;
        low = 0;
        while (!pad_rdy_o) begin
            low++;
            if (low > TIMEOUT_CYCLES) begin
                abort_run("timeout waiting for pad_rdy_o to rise after word 15");
            end
            @(negedge clk);
        end
        check_value("pad_rdy_o low cycles", RDY_LOW_CYCLES, low);
    endtask

    task automatic send_block(input blk_arr_t words, input logic lst, input bit irregular);
        int hold_at;
        int gap;
        hold_at = 1 + rand_below(3);  // stall after one to three prefetched words
        queue_expected(words, lst);
        for (int i = 0; i < `SM3_BLK_WORDS; i++) begin
            gap = 0;
            if (irregular) begin
                if (i == hold_at) begin
                    gap = 6 + rand_below(4);
                end else if (i >= `SM3_PRE_WORDS) begin
                    gap = rand_below(4);
                end
            end
            repeat (gap) @(negedge clk);
            send_word(words[i], lst);
        end
        measure_ready_low();
    endtask

    task automatic wait_drained();
        int cyc;
        cyc = 0;
        while (exp_wj_q.size() != 0) begin
            cyc++;
            if (cyc > TIMEOUT_CYCLES) begin
                abort_run("timeout waiting for all expected pairs to come out");
            end
            @(negedge clk);
        end
        check_value("pad_rdy_o", 1, pad_rdy_o);
        repeat (4) @(negedge clk);  // a stray pair would show up here
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare process
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst_n) begin
            if (expnd_vld_o) begin
                if (exp_wj_q.size() == 0) begin
                    abort_run("DUT produced an output pair that no block accounts for");
                end else begin
                    check_value("wj_o", exp_wj_q.pop_front(), wj_o);
                    check_value("wjj_o", exp_wjj_q.pop_front(), wjj_o);
                    check_value("expnd_lst_o", exp_lst_q.pop_front(), expnd_lst_o);
                    pairs_seen++;
                end
            end else begin
                check_value("expnd_lst_o", 0, expnd_lst_o);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int cyc;
        seed           = 32'he0749e56;
        pairs_expected = 0;
        pairs_seen     = 0;
        pad_d_i        = '0;
        pad_vld_i      = 1'b0;
        pad_lst_i      = 1'b0;

        // reset state, during and right after reset
        cyc = 0;
        @(negedge clk);
        while (!rst_n) begin
            check_value("pad_rdy_o", 1, pad_rdy_o);
            check_value("expnd_vld_o", 0, expnd_vld_o);
            check_value("expnd_lst_o", 0, expnd_lst_o);
            cyc++;
            if (cyc > TIMEOUT_CYCLES) begin
                abort_run("timeout waiting for reset to be released");
            end
            @(negedge clk);
        end
        repeat (2) begin
            check_value("pad_rdy_o", 1, pad_rdy_o);
            check_value("expnd_vld_o", 0, expnd_vld_o);
            check_value("expnd_lst_o", 0, expnd_lst_o);
            @(negedge clk);
        end

        // single last block from idle
        fill_random_block();
        send_block(blk, 1'b1, 1'b0);
        wait_drained();

        // three blocks back to back, next heads go through the prefetch buffer
        for (int b = 0; b < 3; b++) begin
            fill_random_block();
            send_block(blk, (b == 2), 1'b0);
        end
        wait_drained();

        // random gaps and stalls with a partly filled prefetch buffer
        for (int b = 0; b < 4; b++) begin
            fill_random_block();
            send_block(blk, (b == 3), 1'b1);
        end
        wait_drained();

        if (exp_wj_q.size() == 0 && pairs_seen == pairs_expected) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("number of output pairs does not match the blocks sent");
        end
    end

endmodule
